// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := exec_unit_tb
FILELIST  := compile.f
RUNFLAGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) | tee $(LOG)
	grep -qx "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
verilog/rv32_isa_pkg.sv
verilog/exec_types_pkg.sv
verilog/exec_bus_if.sv
verilog/pipe_stage.sv
verilog/operand_select.sv
verilog/arithmetic_logic_unit.sv
verilog/branch_target_unit.sv
verilog/exec_unit_top.sv
tests/exec_unit_props.sv
tests/exec_unit_tb.sv

// File: tests/exec_unit_props.sv
// ----------------------------------------------------------------------
// Execute stage properties
// Concurrent checks on the valid pipeline and the branch outputs
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_unit_props (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                issue_valid_i,
    input logic                result_valid_i,
    input rv32_isa_pkg::xlen_t target_i,
    input logic                is_branch_i,
    input logic                branch_taken_i
);

    // Read by the testbench at the end of the run
    int unsigned assert_failures = 0;

    // Nothing may leave the result register while reset holds
    reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !result_valid_i)
        else begin
            assert_failures++;
            $error("result valid was set during reset");
        end

    // Fixed latency of two cycles from issue to result
    fixed_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(arst_n_i, 2) |-> result_valid_i == $past(issue_valid_i, 2))
        else begin
            assert_failures++;
            $error("result valid does not follow issue valid by two cycles");
        end

    // A taken outcome only exists for jumps and branches
    taken_is_branch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        branch_taken_i |-> is_branch_i)
        else begin
            assert_failures++;
            $error("taken flag set on a non-branch result");
        end

    non_branch_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !is_branch_i |-> target_i == '0)
        else begin
            assert_failures++;
            $error("non-zero target on a non-branch result");
        end

endmodule : exec_unit_props

// File: tests/exec_unit_tb.sv
// ----------------------------------------------------------------------
// Execute stage testbench
// Random micro-operations against a reference model, checked in
// issue order as results leave the result register
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_unit_tb;
    import rv32_isa_pkg::*;
    import exec_types_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_RR   = 150;
    localparam int N_IMM  = 150;
    localparam int N_BR   = 120;
    localparam int N_JUMP = 80;
    localparam int N_MIX  = 200;
    localparam int MIX_TEST = 5;
    localparam int TOTAL_OPS = N_RR + N_IMM + N_BR + N_JUMP + N_MIX;
    localparam int CYCLE_LIMIT = TOTAL_OPS * 2 + 100;

    logic       clk_i;
    logic       arst_n_i;
    logic       issue_valid_i;
    alu_uops_t  issue_op_i;
    xlen_t      rs1_data_i;
    xlen_t      rs2_data_i;
    xlen_t      imm_i;
    xlen_t      pc_i;
    logic       compressed_i;
    logic       result_valid_o;
    xlen_t      result_o;
    xlen_t      target_o;
    logic       is_branch_o;
    logic       branch_taken_o;

    integer     seed = 32'h30a77524;
    commit_t    exp_q[$];
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;

    exec_unit_top u_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .imm_i          (imm_i),
        .pc_i           (pc_i),
        .compressed_i   (compressed_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .is_branch_o    (is_branch_o),
        .branch_taken_o (branch_taken_o)
    );

    bind exec_unit_top exec_unit_props u_props (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .result_valid_i (result_valid_o),
        .target_i       (target_o),
        .is_branch_i    (is_branch_o),
        .branch_taken_i (branch_taken_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end : clock_gen

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // Expected commit written straight from the RV32I rules
    function automatic commit_t expected_commit(input alu_uops_t op, input xlen_t rs1,
                                                input xlen_t rs2, input xlen_t imm,
                                                input xlen_t pc, input logic c);
        commit_t want;
        xlen_t   link;
        xlen_t   imm_sx;
        want   = '0;
        link   = pc + (c ? 32'd2 : 32'd4);
        imm_sx = {{20{imm[11]}}, imm[11:0]};
        case (op)
            ADD:   want.result = rs1 + rs2;
            ADDI:  want.result = rs1 + imm;
            SUB:   want.result = rs1 - rs2;
            SLT:   want.result = {31'b0, $signed(rs1) < $signed(rs2)};
            SLTI:  want.result = {31'b0, $signed(rs1) < $signed(imm)};
            SLTU:  want.result = {31'b0, rs1 < rs2};
            SLTIU: want.result = {31'b0, rs1 < imm_sx};
            AND:   want.result = rs1 & rs2;
            ANDI:  want.result = rs1 & imm;
            OR:    want.result = rs1 | rs2;
            ORI:   want.result = rs1 | imm;
            XOR:   want.result = rs1 ^ rs2;
            XORI:  want.result = rs1 ^ imm;
            SLL:   want.result = rs1 << rs2[4:0];
            SLLI:  want.result = rs1 << imm[4:0];
            SRL:   want.result = rs1 >> rs2[4:0];
            SRLI:  want.result = rs1 >> imm[4:0];
            SRA:   want.result = xlen_t'($signed(rs1) >>> rs2[4:0]);
            SRAI:  want.result = xlen_t'($signed(rs1) >>> imm[4:0]);
            LUI:   want.result = imm;
            AUIPC: want.result = pc + imm;
            JAL, JALR: begin
                want.result    = link;
                want.is_branch = 1'b1;
                want.taken     = 1'b1;
                want.target    = (op == JALR) ? ((rs1 + imm) & 32'hffff_fffe) : pc + imm;
            end
            default: begin
                // Conditional branches write no register
                want.is_branch = 1'b1;
                want.target    = pc + imm;
                case (op)
                    BEQ:     want.taken = (rs1 == rs2);
                    BNE:     want.taken = (rs1 != rs2);
                    BLT:     want.taken = $signed(rs1) < $signed(rs2);
                    BLTU:    want.taken = rs1 < rs2;
                    BGE:     want.taken = $signed(rs1) >= $signed(rs2);
                    default: want.taken = rs1 >= rs2;
                endcase
            end
        endcase
        return want;
    endfunction

    // ------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------

    task automatic check_word(input string name, input xlen_t got, input xlen_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("Error at %0t ns: %s is %08h, expected %08h", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // Each valid result is matched against the oldest outstanding operation
    always @(negedge clk_i) begin : result_monitor
        commit_t want;
        if (!arst_n_i) begin
            if (result_valid_o !== 1'b0) report_failure("a result was valid during reset");
        end else if (result_valid_o) begin
            if (exp_q.size() == 0) begin
                report_failure("a result appeared with no operation outstanding");
            end else begin
                want = exp_q.pop_front();
                check_word("result_o", result_o, want.result);
                check_word("target_o", target_o, want.target);
                check_flag("is_branch_o", is_branch_o, want.is_branch);
                check_flag("branch_taken_o", branch_taken_o, want.taken);
            end
        end
    end : result_monitor

    always @(posedge clk_i) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end : watchdog

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    function automatic xlen_t rand_word();
        return xlen_t'($random(seed));
    endfunction

    // One operand in four comes from the signed and unsigned corner values
    function automatic xlen_t pick_operand();
        xlen_t r;
        r = rand_word();
        if (r[1:0] != 2'b00) return rand_word();
        case (r[4:2])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'h8000_0000;
            3'd4:    return 32'hffff_ffff;
            3'd5:    return 32'hffff_f800;
            3'd6:    return 32'h0000_0800;
            default: return 32'h0000_07ff;
        endcase
    endfunction

    function automatic alu_uops_t pick_op(input int test_id);
        xlen_t      r;
        logic [4:0] code;
        r = rand_word();
        case (test_id)
            1: begin
                case (r % 10)
                    0:       return ADD;
                    1:       return SUB;
                    2:       return SLT;
                    3:       return SLTU;
                    4:       return AND;
                    5:       return OR;
                    6:       return XOR;
                    7:       return SLL;
                    8:       return SRL;
                    default: return SRA;
                endcase
            end
            2: begin
                case (r % 11)
                    0:       return ADDI;
                    1:       return SLTI;
                    2:       return SLTIU;
                    3:       return ANDI;
                    4:       return ORI;
                    5:       return XORI;
                    6:       return SLLI;
                    7:       return SRLI;
                    8:       return SRAI;
                    9:       return LUI;
                    default: return AUIPC;
                endcase
            end
            // The six conditional branches sit together at the end of the enum
            3: code = 5'(BEQ) + 5'(r % 6);
            4: return r[0] ? JAL : JALR;
            default: code = 5'(r % 29);
        endcase
        return alu_uops_t'(code);
    endfunction

    task automatic drive_idle();
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        rs1_data_i    <= rand_word();
        rs2_data_i    <= rand_word();
    endtask

    // Issue one operation and queue the commit the model expects for it
    task automatic issue_random(input alu_uops_t op);
        xlen_t rs1;
        xlen_t rs2;
        xlen_t imm;
        xlen_t pc;
        xlen_t r;
        logic  c;
        rs1 = pick_operand();
        rs2 = pick_operand();
        r   = rand_word();
        pc  = {r[31:1], 1'b0};
        r   = rand_word();
        c   = r[31];
        case (op)
            // Amounts 0 and 31 come up one time in four each
            SLLI, SRLI, SRAI: imm = (r[1:0] == 2'd0) ? 32'd0 :
                                    (r[1:0] == 2'd1) ? 32'd31 : {27'b0, r[6:2]};
            // Half of the SLTIU immediates carry noise above bit 11 that must not count
            SLTIU:            imm = r[13] ? r : {{20{r[11]}}, r[11:0]};
            LUI, AUIPC:       imm = {r[19:0], 12'h000};
            JAL:              imm = {{11{r[20]}}, r[20:1], 1'b0};
            BEQ, BNE, BLT, BLTU, BGE, BGEU: begin
                imm = {{19{r[12]}}, r[12:1], 1'b0};
                if (r[0]) rs2 = rs1;
            end
            default:          imm = {{20{r[11]}}, r[11:0]};
        endcase
        @(posedge clk_i);
        issue_valid_i <= 1'b1;
        issue_op_i    <= op;
        rs1_data_i    <= rs1;
        rs2_data_i    <= rs2;
        imm_i         <= imm;
        pc_i          <= pc;
        compressed_i  <= c;
        exp_q.push_back(expected_commit(op, rs1, rs2, imm, pc, c));
    endtask

    task automatic run_test(input int test_id, input string name, input int slots);
        int    errors_before;
        int    issued;
        xlen_t r;
        errors_before = error_count;
        issued = 0;
        for (int i = 0; i < slots; i++) begin
            r = rand_word();
            if (test_id == MIX_TEST && r[1:0] == 2'b00) begin
                drive_idle();
            end else begin
                issue_random(pick_op(test_id));
                issued++;
            end
        end
        drive_idle();
        while (exp_q.size() != 0) @(negedge clk_i);
        // A few quiet cycles catch any result without an operation
        repeat (2) drive_idle();
        $display("Test %0d (%s): %0d operations, %0d errors", test_id, name, issued,
                 error_count - errors_before);
    endtask

    initial begin : stimulus
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = ADD;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        imm_i         = '0;
        pc_i          = '0;
        compressed_i  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        run_test(1, "register-register operations", N_RR);
        run_test(2, "immediate forms, LUI and AUIPC", N_IMM);
        run_test(3, "conditional branches", N_BR);
        run_test(4, "JAL and JALR", N_JUMP);
        run_test(MIX_TEST, "mixed valid pattern", N_MIX);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
                 error_count, u_dut.u_props.assert_failures);
        if (error_count == 0 && u_dut.u_props.assert_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end : stimulus

endmodule : exec_unit_tb

// File: verilog/arithmetic_logic_unit.sv
// ----------------------------------------------------------------------
// Arithmetic logic unit
// Combinational RV32I datapath with one adder, comparators, a shifter
// and logic operations, plus the branch outcome for jumps and branches
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module arithmetic_logic_unit (
    exec_bus_if.alu              bus,
    output rv32_isa_pkg::xlen_t  result_o,
    output logic                 is_branch_o,
    output logic                 branch_taken_o
);
    import rv32_isa_pkg::*;

    // ------------------------------------------------------------------
    // Adder
    // ------------------------------------------------------------------

    logic  subtract;
    xlen_t adder_b;
    xlen_t adder_result;

    // SUB shares the adder as A plus the two's complement of B
    assign subtract     = (bus.op == SUB);
    assign adder_b      = subtract ? ~bus.operand_b : bus.operand_b;
    assign adder_result = bus.operand_a + adder_b + {{(XLEN-1){1'b0}}, subtract};

    // Return address written by JAL and JALR
    xlen_t link_addr;

    assign link_addr = bus.pc + (bus.compressed ? xlen_t'(LINK_OFFSET_RVC)
                                                : xlen_t'(LINK_OFFSET));

    // ------------------------------------------------------------------
    // Comparators
    // ------------------------------------------------------------------

    xlen_t compare_b;
    logic  lt_s;
    logic  lt_u;
    logic  ge_s;
    logic  ge_u;
    logic  equal;

    // SLTIU sign-extends its 12-bit immediate and then compares unsigned
    assign compare_b = (bus.op == SLTIU) ?
                       {{(XLEN-IMM_W){bus.operand_b[IMM_W-1]}}, bus.operand_b[IMM_W-1:0]} :
                       bus.operand_b;

    assign lt_s  = $signed(bus.operand_a) < $signed(compare_b);
    assign lt_u  = bus.operand_a < compare_b;
    assign ge_s  = $signed(bus.operand_a) >= $signed(bus.operand_b);
    assign ge_u  = bus.operand_a >= bus.operand_b;
    assign equal = (bus.operand_a == bus.operand_b);

    // Jumps are always taken, branches follow their comparison
    // Nothing is flagged for an empty slot
    always_comb begin : branch_outcome
        is_branch_o    = 1'b0;
        branch_taken_o = 1'b0;
        if (bus.valid) begin
            is_branch_o = 1'b1;
            case (bus.op)
                JAL, JALR: branch_taken_o = 1'b1;
                BEQ:       branch_taken_o = equal;
                BNE:       branch_taken_o = !equal;
                BLT:       branch_taken_o = lt_s;
                BLTU:      branch_taken_o = lt_u;
                BGE:       branch_taken_o = ge_s;
                BGEU:      branch_taken_o = ge_u;
                default:   is_branch_o = 1'b0;
            endcase
        end
    end : branch_outcome

    // ------------------------------------------------------------------
    // Shifter and logic
    // ------------------------------------------------------------------

    logic [SHAMT_W-1:0] shamt;
    xlen_t              sll_result;
    xlen_t              srl_result;
    xlen_t              sra_result;

    // Only the low five bits of B count as shift amount
    assign shamt      = bus.operand_b[SHAMT_W-1:0];
    assign sll_result = bus.operand_a << shamt;
    assign srl_result = bus.operand_a >> shamt;
    assign sra_result = $signed(bus.operand_a) >>> shamt;

    // ------------------------------------------------------------------
    // Result mux
    // ------------------------------------------------------------------

    always_comb begin : result_mux
        case (bus.op)
            ADD, ADDI, SUB, AUIPC: result_o = adder_result;
            SLT, SLTI:             result_o = {{(XLEN-1){1'b0}}, lt_s};
            SLTU, SLTIU:           result_o = {{(XLEN-1){1'b0}}, lt_u};
            AND, ANDI:             result_o = bus.operand_a & bus.operand_b;
            OR, ORI:               result_o = bus.operand_a | bus.operand_b;
            XOR, XORI:             result_o = bus.operand_a ^ bus.operand_b;
            SLL, SLLI:             result_o = sll_result;
            SRL, SRLI:             result_o = srl_result;
            SRA, SRAI:             result_o = sra_result;
            // The decoder hands LUI its upper immediate ready to write
            LUI:                   result_o = bus.operand_b;
            JAL, JALR:             result_o = link_addr;
            // Conditional branches write no register
            default:               result_o = '0;
        endcase
    end : result_mux

endmodule : arithmetic_logic_unit

// File: verilog/branch_target_unit.sv
// ----------------------------------------------------------------------
// Branch target unit
// Destination address for jumps and conditional branches
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module branch_target_unit (
    exec_bus_if.branch           bus,
    output rv32_isa_pkg::xlen_t  target_o
);
    import rv32_isa_pkg::*;

    xlen_t base;
    xlen_t sum;

    // JALR is register relative, every other jump is PC relative
    assign base = (bus.op == JALR) ? bus.rs1 : bus.pc;
    assign sum  = base + bus.imm;

    // ------------------------------------------------------------------
    // Target select
    // ------------------------------------------------------------------

    always_comb begin : target_select
        target_o = '0;
        // Empty slots and plain ALU operations leave the target at zero
        if (bus.valid) begin
            case (bus.op)
                // The spec clears bit 0 of the computed JALR address
                JALR: target_o = {sum[XLEN-1:1], 1'b0};

                JAL,
                BEQ, BNE,
                BLT, BLTU,
                BGE, BGEU: target_o = sum;

                default: target_o = '0;
            endcase
        end
    end : target_select

endmodule : branch_target_unit

// File: verilog/exec_bus_if.sv
// ----------------------------------------------------------------------
// Execute bus
// Selected operands from the operand selector to the ALU and the
// branch target unit
// ----------------------------------------------------------------------

`timescale 1ns/1ns

interface exec_bus_if;
    import rv32_isa_pkg::*;

    logic      valid;
    alu_uops_t op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     pc;
    xlen_t     rs1;
    xlen_t     imm;
    logic      compressed;

    // The selector drives every signal of the bus
    modport selector (
        output valid, op, operand_a, operand_b, pc, rs1, imm, compressed
    );

    // The ALU works on the muxed operands and needs the PC for links
    modport alu (
        input valid, op, operand_a, operand_b, pc, compressed
    );

    // JALR adds to rs1, the other jumps add to the PC
    modport branch (
        input valid, op, pc, rs1, imm
    );

endinterface : exec_bus_if

// File: verilog/exec_types_pkg.sv
// ----------------------------------------------------------------------
// Execute stage payload types
// Issue request and committed result as they travel through the stage
// ----------------------------------------------------------------------

package exec_types_pkg;

    // One decoded micro-operation as captured by the issue register
    typedef struct packed {
        rv32_isa_pkg::alu_uops_t op;
        rv32_isa_pkg::xlen_t     rs1;
        rv32_isa_pkg::xlen_t     rs2;
        // Already sign-extended by the decoder
        rv32_isa_pkg::xlen_t     imm;
        rv32_isa_pkg::xlen_t     pc;
        // Set for a 16-bit instruction, moves the link address by 2
        logic                    compressed;
    } issue_req_t;

    // Outcome of one operation as held by the result register
    typedef struct packed {
        rv32_isa_pkg::xlen_t result;
        // Jump or branch destination, zero for everything else
        rv32_isa_pkg::xlen_t target;
        logic                is_branch;
        logic                taken;
    } commit_t;

endpackage : exec_types_pkg

// File: verilog/exec_unit_top.sv
// ----------------------------------------------------------------------
// Execute stage top level
// Issue register, operand selector, ALU, branch target unit and
// result register, with a fixed latency of two cycles
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_unit_top (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    issue_valid_i,
    input  rv32_isa_pkg::alu_uops_t issue_op_i,
    input  rv32_isa_pkg::xlen_t     rs1_data_i,
    input  rv32_isa_pkg::xlen_t     rs2_data_i,
    input  rv32_isa_pkg::xlen_t     imm_i,
    input  rv32_isa_pkg::xlen_t     pc_i,
    input  logic                    compressed_i,
    output logic                    result_valid_o,
    output rv32_isa_pkg::xlen_t     result_o,
    output rv32_isa_pkg::xlen_t     target_o,
    output logic                    is_branch_o,
    output logic                    branch_taken_o
);
    import rv32_isa_pkg::*;
    import exec_types_pkg::*;

    issue_req_t issue_d;
    issue_req_t issue_q;
    logic       issue_valid_q;
    commit_t    commit_d;
    commit_t    commit_q;
    xlen_t      alu_result;
    xlen_t      bt_target;
    logic       alu_is_branch;
    logic       alu_taken;

    exec_bus_if u_bus ();

    // ------------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------------

    assign issue_d = '{op: issue_op_i, rs1: rs1_data_i, rs2: rs2_data_i,
                       imm: imm_i, pc: pc_i, compressed: compressed_i};

    pipe_stage #(.payload_t(issue_req_t)) u_issue_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (issue_valid_i),
        .data_i   (issue_d),
        .valid_o  (issue_valid_q),
        .data_o   (issue_q)
    );

    operand_select u_operand_select (
        .valid_i (issue_valid_q),
        .req_i   (issue_q),
        .bus     (u_bus.selector)
    );

    // ------------------------------------------------------------------
    // Execute and commit
    // ------------------------------------------------------------------

    arithmetic_logic_unit u_alu (
        .bus            (u_bus.alu),
        .result_o       (alu_result),
        .is_branch_o    (alu_is_branch),
        .branch_taken_o (alu_taken)
    );

    branch_target_unit u_branch_target (
        .bus      (u_bus.branch),
        .target_o (bt_target)
    );

    assign commit_d = '{result: alu_result, target: bt_target,
                        is_branch: alu_is_branch, taken: alu_taken};

    pipe_stage #(.payload_t(commit_t)) u_result_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (issue_valid_q),
        .data_i   (commit_d),
        .valid_o  (result_valid_o),
        .data_o   (commit_q)
    );

    assign result_o       = commit_q.result;
    assign target_o       = commit_q.target;
    assign is_branch_o    = commit_q.is_branch;
    assign branch_taken_o = commit_q.taken;

endmodule : exec_unit_top

// File: verilog/operand_select.sv
// ----------------------------------------------------------------------
// Operand selector
// Picks the sources of operands A and B for each micro-operation and
// drives the execute bus
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module operand_select (
    input  logic                       valid_i,
    input  exec_types_pkg::issue_req_t req_i,
    exec_bus_if.selector               bus
);
    import rv32_isa_pkg::*;

    logic pc_as_a;
    logic imm_as_b;

    // ------------------------------------------------------------------
    // Source decode
    // ------------------------------------------------------------------

    // AUIPC and JAL add to the instruction address
    always_comb begin : a_source
        case (req_i.op)
            AUIPC, JAL: pc_as_a = 1'b1;
            default:    pc_as_a = 1'b0;
        endcase
    end : a_source

    // All I-type forms plus the U-type and jump forms take the immediate
    always_comb begin : b_source
        case (req_i.op)
            ADDI, SLTI, SLTIU, ANDI, ORI, XORI,
            SLLI, SRLI, SRAI,
            LUI, AUIPC, JAL, JALR: imm_as_b = 1'b1;
            default:               imm_as_b = 1'b0;
        endcase
    end : b_source

    // ------------------------------------------------------------------
    // Bus drive
    // ------------------------------------------------------------------

    assign bus.valid     = valid_i;
    assign bus.op        = req_i.op;
    assign bus.operand_a = pc_as_a ? req_i.pc : req_i.rs1;
    assign bus.operand_b = imm_as_b ? req_i.imm : req_i.rs2;

    // Raw fields for the link address and the branch target
    assign bus.pc         = req_i.pc;
    assign bus.rs1        = req_i.rs1;
    assign bus.imm        = req_i.imm;
    assign bus.compressed = req_i.compressed;

endmodule : operand_select

// File: verilog/pipe_stage.sv
// ----------------------------------------------------------------------
// Pipeline register
// One valid bit with asynchronous clear and one payload register
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Valid is the only control state, it comes up empty after reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end : valid_reg

    // The payload follows the input every cycle
    // Its content only counts while valid_q is set
    always_ff @(posedge clk_i) begin : data_reg
        data_q <= data_i;
    end : data_reg

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : pipe_stage

// File: verilog/rv32_isa_pkg.sv
// ----------------------------------------------------------------------
// RV32I instruction-set definitions
// Data width, data word type and the ALU micro-operation encoding
// ----------------------------------------------------------------------

package rv32_isa_pkg;

    // Width of one integer register in RV32I
    localparam int XLEN = 32;

    // Shift amount field width, taken from the low bits of operand B
    localparam int SHAMT_W = 5;

    // Width of the I-type immediate field in the instruction word
    localparam int IMM_W = 12;

    // Link address offsets for a compressed and a full-size jump
    localparam int LINK_OFFSET_RVC = 2;
    localparam int LINK_OFFSET = 4;

    typedef logic [XLEN-1:0] xlen_t;

    // Every operation the ALU executes, register and immediate forms apart
    typedef enum logic [4:0] {
        ADD,   ADDI,  SUB,
        SLT,   SLTI,  SLTU,  SLTIU,
        AND,   ANDI,
        OR,    ORI,
        XOR,   XORI,
        SLL,   SLLI,
        SRL,   SRLI,
        SRA,   SRAI,
        LUI,   AUIPC,
        // Unconditional jumps
        JAL,   JALR,
        // Conditional branches
        BEQ,   BNE,
        BLT,   BLTU,
        BGE,   BGEU
    } alu_uops_t;

endpackage : rv32_isa_pkg
